// File: rtl/soc_settings.svh
// build-time constants for the debug write path; values are fixed per build, not run-time registers
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// command FIFO address width, 2^5 = 32 entries
// one slot always stays free so full and empty can be told apart
`define DBG_FIFO_AW 5

// region code, compared with address bits 31:28
`define REGION_MISC 4'h2

// flash select delay counter start value
// fsel_c is decoded from counts 5 to 3 of this countdown
`define FSEL_DELAY_START 3'd7

// key in bits 31:8 of a FLASH_SEL write that requests an FPGA reload
// low byte of that write still carries the flash select level in bit 0
`define RELOAD_KEY 24'hd0f1a5

`endif

// File: rtl/soc_bus_pkg.sv
// types for the debug command words and the internal 32-bit write-only bus; no read path exists
`default_nettype none

package soc_bus_pkg;

	// one address or data word on the internal bus
	typedef logic [31:0] word_t;

	// debug command word as pushed by the host
	// is_addr high loads the bus master pointer, low makes one write
	typedef struct packed {
		logic  is_addr;
		word_t value;
	} dbg_cmd_t;

	// bus writes always cover the full word, byte strobes are not carried
	// addresses advance in steps of one word
	localparam int WORD_BYTES = 4;

	// a write is a single cycle when ready answers at once
	// slaves that need wait states simply hold ready low

endpackage

`default_nettype wire

// File: rtl/soc_misc_pkg.sv
// misc register block types; register index comes from address bits 6:2 and only the listed indices exist
`default_nettype none

package soc_misc_pkg;

	// register indices within the misc region
	// gaps belong to registers that are not implemented here
	typedef enum logic [4:0] {
		reg_led       = 5'd0,
		reg_flash_sel = 5'd11,
		reg_genio_out = 5'd15,
		reg_genio_oe  = 5'd16,
		reg_genio_w2s = 5'd17,
		reg_genio_w2c = 5'd18
	} misc_reg_e;

	// general purpose IO, output level and output enable
	typedef logic [29:0] genio_t;

	// LED outputs, taken from the low half of a write
	typedef logic [15:0] led_t;

	// w2s and w2c act on genio_out only
	// genio_oe is always written as a whole

endpackage

`default_nettype wire

// File: rtl/dbg_cmd_fifo.sv
// debug command FIFO without back-pressure: the writer must never push into a full FIFO (31 usable slots)
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module dbg_cmd_fifo (
	input  wire                    clk48m,
	input  wire                    rst,
	input  wire                    push,
	input  wire soc_bus_pkg::dbg_cmd_t push_data,
	input  wire                    pop,
	output soc_bus_pkg::dbg_cmd_t  head,
	output logic                   empty
);

	localparam int DEPTH = 1 << `DBG_FIFO_AW;

	soc_bus_pkg::dbg_cmd_t mem [0:DEPTH-1];

	logic [`DBG_FIFO_AW-1:0] wr_ptr;
	logic [`DBG_FIFO_AW-1:0] rd_ptr;
	logic [`DBG_FIFO_AW-1:0] wr_next;
	logic                    full;

	assign wr_next = wr_ptr + 1'b1;
	assign empty   = (wr_ptr == rd_ptr);
	// one slot is sacrificed so that equal pointers always mean empty
	assign full    = (wr_next == rd_ptr);
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_next;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage itself needs no reset
	always_ff @(posedge clk48m) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// host has no way to see full, overrun would silently drop words
	a_no_push_full: assert property (@(posedge clk48m) disable iff (rst) !(push && full));
	a_no_pop_empty: assert property (@(posedge clk48m) disable iff (rst) !(pop && empty));

endmodule

`default_nettype wire

// File: rtl/dbg_bus_master.sv
// debug bus master: one write per data word, pointer advances by one word; hold blocks pops while the host pushes
`timescale 1ns/100ps
`default_nettype none

module dbg_bus_master (
	input  wire                    clk48m,
	input  wire                    rst,
	input  wire soc_bus_pkg::dbg_cmd_t head,
	input  wire                    empty,
	input  wire                    hold,
	input  wire                    bus_ready,
	output logic                   pop,
	output logic                   bus_valid,
	output soc_bus_pkg::word_t     bus_addr,
	output soc_bus_pkg::word_t     bus_wdata
);

	typedef enum logic {
		st_idle,
		st_write
	} state_e;

	state_e state;

	// host strobe wins, the FIFO sees either a push or a pop in a cycle
	assign pop       = (state == st_idle) && !empty && !hold;
	assign bus_valid = (state == st_write);

	// bus_addr doubles as the write pointer
	always_ff @(posedge clk48m) begin
		if (rst) begin
			state    <= st_idle;
			bus_addr <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (pop) begin
						if (head.is_addr)
							bus_addr <= head.value;
						else
							state <= st_write;
					end
				end
				st_write: begin
					// write lands at this edge, move on to the next word
					if (bus_ready) begin
						bus_addr <= bus_addr + soc_bus_pkg::word_t'(soc_bus_pkg::WORD_BYTES);
						state    <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// data is only captured when a data word leaves the FIFO
	always_ff @(posedge clk48m) begin
		if (pop && !head.is_addr)
			bus_wdata <= head.value;
	end

	// slave may stall, the transfer must not change under it
	a_stable_while_wait: assert property (@(posedge clk48m) disable iff (rst)
		bus_valid && !bus_ready |=> $stable(bus_addr) && $stable(bus_wdata));

endmodule

`default_nettype wire

// File: rtl/misc_reg_slave.sv
// misc register slave, write only: only region 0x2 is decoded, any other region answers at once and flags a bus error
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module misc_reg_slave (
	input  wire                     clk48m,
	input  wire                     rst,
	input  wire                     bus_valid,
	input  wire soc_bus_pkg::word_t bus_addr,
	input  wire soc_bus_pkg::word_t bus_wdata,
	output logic                    bus_ready,
	output soc_misc_pkg::led_t      led,
	output soc_misc_pkg::genio_t    genio_out,
	output soc_misc_pkg::genio_t    genio_oe,
	output logic                    fsel_d,
	output logic                    fsel_strobe,
	output logic                    reload_req,
	output logic                    irq_bus_error
);

	logic                    region_misc;
	logic                    misc_wr;
	logic                    err_wr;
	soc_misc_pkg::misc_reg_e reg_idx;
	soc_misc_pkg::genio_t    wr_genio;

	assign region_misc = (bus_addr[31:28] == `REGION_MISC);
	assign reg_idx     = soc_misc_pkg::misc_reg_e'(bus_addr[6:2]);
	assign wr_genio    = bus_wdata[29:0];

	// every region answers in the same cycle, errors included
	assign bus_ready = bus_valid;

	assign misc_wr = bus_valid && bus_ready && region_misc;
	assign err_wr  = bus_valid && bus_ready && !region_misc;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led           <= '0;
			genio_out     <= '0;
			genio_oe      <= '0;
			fsel_d        <= 1'b0;
			fsel_strobe   <= 1'b0;
			reload_req    <= 1'b0;
			irq_bus_error <= 1'b0;
		end else begin
			fsel_strobe   <= 1'b0;
			irq_bus_error <= err_wr;
			if (misc_wr) begin
				case (reg_idx)
					soc_misc_pkg::reg_led: led <= bus_wdata[15:0];
					soc_misc_pkg::reg_genio_out: genio_out <= wr_genio;
					soc_misc_pkg::reg_genio_oe: genio_oe <= wr_genio;
					soc_misc_pkg::reg_genio_w2s: genio_out <= genio_out | wr_genio;
					soc_misc_pkg::reg_genio_w2c: genio_out <= genio_out & ~wr_genio;
					soc_misc_pkg::reg_flash_sel: begin
						fsel_d      <= bus_wdata[0];
						fsel_strobe <= 1'b1;
						// keyed write arms the reload, nothing but reset disarms it
						if (bus_wdata[31:8] == `RELOAD_KEY)
							reload_req <= 1'b1;
					end
					// unimplemented indices are dropped
					default: ;
				endcase
			end
		end
	end

	// master needs a pop cycle between writes, so strobes never touch
	a_strobe_single: assert property (@(posedge clk48m) disable iff (rst)
		fsel_strobe |=> !fsel_strobe);

	// error interrupt is a single pulse per error write
	a_irq_single: assert property (@(posedge clk48m) disable iff (rst)
		irq_bus_error |=> !irq_bus_error);

endmodule

`default_nettype wire

// File: rtl/flash_reload_timer.sv
// flash select timer: fsel_c pulses 3 cycles after each strobe, programn stays low after a keyed reload until reset
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module flash_reload_timer (
	input  wire  clk48m,
	input  wire  rst,
	input  wire  fsel_strobe,
	input  wire  reload_req,
	output logic fsel_c,
	output logic programn
);

	logic [2:0] fsel_delay;
	logic       fpga_reload;

	// clock the select flop in the middle of the countdown
	// so fsel_d has settled well before and after the edge
	assign fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);

	// programn is active low
	assign programn = ~fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay  <= '0;
			fpga_reload <= 1'b0;
		end else begin
			if (fsel_strobe) begin
				fsel_delay <= `FSEL_DELAY_START;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
				// reload only once the new flash select is latched
				if (fsel_delay == 3'd1 && reload_req)
					fpga_reload <= 1'b1;
			end
		end
	end

	a_fsel_c_counting: assert property (@(posedge clk48m) disable iff (rst)
		fsel_c |-> fsel_delay != 3'd0);

endmodule

`default_nettype wire

// File: rtl/dbg_soc_top.sv
// debug write path top: host strobes must not overrun the 31-word command FIFO, no flow control is returned
`timescale 1ns/100ps
`default_nettype none

module dbg_soc_top (
	input  wire                     clk48m,
	input  wire                     rst,
	input  wire soc_bus_pkg::word_t dbgreg_in,
	input  wire                     dbgreg_sel,
	input  wire                     dbgreg_strobe,
	output soc_misc_pkg::led_t      led,
	output soc_misc_pkg::genio_t    genio_out,
	output soc_misc_pkg::genio_t    genio_oe,
	output logic                    fsel_d,
	output logic                    fsel_c,
	output logic                    programn,
	output logic                    irq_bus_error
);

	soc_bus_pkg::dbg_cmd_t fifo_in;
	soc_bus_pkg::dbg_cmd_t fifo_head;
	logic                  fifo_empty;
	logic                  fifo_pop;
	logic                  bus_valid;
	logic                  bus_ready;
	soc_bus_pkg::word_t    bus_addr;
	soc_bus_pkg::word_t    bus_wdata;
	logic                  fsel_strobe;
	logic                  reload_req;

	// sel marks the word as an address
	assign fifo_in = '{is_addr: dbgreg_sel, value: dbgreg_in};

	dbg_cmd_fifo u_fifo (
		.clk48m    (clk48m),
		.rst       (rst),
		.push      (dbgreg_strobe),
		.push_data (fifo_in),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.empty     (fifo_empty)
	);

	dbg_bus_master u_master (
		.clk48m    (clk48m),
		.rst       (rst),
		.head      (fifo_head),
		.empty     (fifo_empty),
		.hold      (dbgreg_strobe),
		.bus_ready (bus_ready),
		.pop       (fifo_pop),
		.bus_valid (bus_valid),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata)
	);

	misc_reg_slave u_misc (
		.clk48m        (clk48m),
		.rst           (rst),
		.bus_valid     (bus_valid),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.bus_ready     (bus_ready),
		.led           (led),
		.genio_out     (genio_out),
		.genio_oe      (genio_oe),
		.fsel_d        (fsel_d),
		.fsel_strobe   (fsel_strobe),
		.reload_req    (reload_req),
		.irq_bus_error (irq_bus_error)
	);

	flash_reload_timer u_timer (
		.clk48m      (clk48m),
		.rst         (rst),
		.fsel_strobe (fsel_strobe),
		.reload_req  (reload_req),
		.fsel_c      (fsel_c),
		.programn    (programn)
	);

endmodule

`default_nettype wire

// File: verif/tb_dbg_soc.sv
// testbench for the debug write path; the host never overfills the FIFO and every wait is bounded
`timescale 1ns/100ps
`default_nettype none

`include "soc_settings.svh"

module tb_dbg_soc;

	localparam int drain_limit = 4 << `DBG_FIFO_AW;

	logic        clk48m;
	logic        rst;
	logic [31:0] dbgreg_in;
	logic        dbgreg_sel;
	logic        dbgreg_strobe;
	logic [15:0] led;
	logic [29:0] genio_out;
	logic [29:0] genio_oe;
	logic        fsel_d;
	logic        fsel_c;
	logic        programn;
	logic        irq_bus_error;

	integer      seed;
	int          errors;
	int          mark;
	int          tests_run;
	int          tests_failed;
	int          irq_count;
	int          rise_dly;
	int          high_cnt;
	int          prog_dly;
	int          i;

	// reference model, updated as words are pushed
	logic [31:0] model_ptr;
	logic [15:0] model_led;
	logic [29:0] model_out;
	logic [29:0] model_oe;
	logic        model_fsel;
	logic        model_armed;
	int          model_irq;

	dbg_soc_top UUT (.*);

	initial begin
		clk48m = 1'b0;
		forever #5 clk48m = ~clk48m;
	end

	always @(posedge clk48m) begin
		if (rst)
			irq_count <= 0;
		else if (irq_bus_error)
			irq_count <= irq_count + 1;
	end

	irq_single_pulse: assert property (@(posedge clk48m) disable iff (rst)
		irq_bus_error |=> !irq_bus_error)
	else begin
		$display("irq_bus_error stayed high for more than one cycle at %0t", $time);
		errors++;
	end

	no_reload_before_key: assert property (@(posedge clk48m) disable iff (rst)
		!model_armed |-> programn)
	else begin
		$display("programn went low without a keyed FLASH_SEL write at %0t", $time);
		errors++;
	end

	function automatic logic [31:0] misc_addr(input logic [4:0] idx);
		return {`REGION_MISC, 21'd0, idx, 2'b00};
	endfunction

	function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
		if (addr[31:28] != `REGION_MISC) begin
			model_irq++;
		end else begin
			case (addr[6:2])
				5'd0: model_led = data[15:0];
				5'd11: begin
					model_fsel = data[0];
					if (data[31:8] == `RELOAD_KEY)
						model_armed = 1'b1;
				end
				5'd15: model_out = data[29:0];
				5'd16: model_oe = data[29:0];
				5'd17: model_out = model_out | data[29:0];
				5'd18: model_out = model_out & ~data[29:0];
				default: ;
			endcase
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("[ERROR] time %0t %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// keep high leaves the strobe asserted for a back-to-back word
	// otherwise one idle cycle follows so the master can pop
	task automatic push_word(input logic sel, input logic [31:0] val, input logic keep);
		dbgreg_sel    = sel;
		dbgreg_in     = val;
		dbgreg_strobe = 1'b1;
		if (sel) begin
			model_ptr = val;
		end else begin
			model_write(model_ptr, val);
			model_ptr = model_ptr + 32'd4;
		end
		@(posedge clk48m);
		#1;
		dbgreg_strobe = keep;
		if (!keep) begin
			@(posedge clk48m);
			#1;
		end
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < drain_limit; n++) begin
			@(posedge clk48m);
			#1;
			if (UUT.fifo_empty && !UUT.bus_valid)
				break;
		end
		if (n == drain_limit) begin
			$display("timeout: the command FIFO did not drain at %0t", $time);
			errors++;
		end
		// irq is registered one cycle after the last write
		@(posedge clk48m);
		#1;
	endtask

	// fixed window, delays are counted from the cycle where fsel_d changes
	task automatic watch_fsel(input logic exp_d);
		int cyc;
		int t0;
		t0       = -1;
		rise_dly = -1;
		high_cnt = 0;
		prog_dly = -1;
		for (cyc = 0; cyc < 40; cyc++) begin
			@(posedge clk48m);
			#1;
			if (t0 < 0 && fsel_d == exp_d)
				t0 = cyc;
			if (t0 >= 0 && fsel_c) begin
				if (rise_dly < 0)
					rise_dly = cyc - t0;
				high_cnt++;
			end
			if (t0 >= 0 && !programn && prog_dly < 0)
				prog_dly = cyc - t0;
		end
		if (t0 < 0) begin
			$display("timeout: fsel_d never changed to %0b", exp_d);
			errors++;
		end
	endtask

	task automatic check_outputs();
		check_value("led", model_led, led);
		check_value("genio_out", model_out, genio_out);
		check_value("genio_oe", model_oe, genio_oe);
		check_value("fsel_d", model_fsel, fsel_d);
		check_value("fsel_c", 0, fsel_c);
		check_value("programn", !model_armed, programn);
		check_value("irq_bus_error", 0, irq_bus_error);
		check_value("irq_bus_error pulses", model_irq, irq_count);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == mark) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		seed          = 32'he631_d5c7;
		errors        = 0;
		mark          = 0;
		tests_run     = 0;
		tests_failed  = 0;
		rst           = 1'b1;
		dbgreg_in     = '0;
		dbgreg_sel    = 1'b0;
		dbgreg_strobe = 1'b0;
		model_ptr     = '0;
		model_led     = '0;
		model_out     = '0;
		model_oe      = '0;
		model_fsel    = 1'b0;
		model_armed   = 1'b0;
		model_irq     = 0;
		repeat (10) @(posedge clk48m);
		#1;
		rst = 1'b0;

		check_outputs();
		end_test("reset values");

		push_word(1'b1, misc_addr(5'd0), 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		push_word(1'b1, misc_addr(5'd15), 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		wait_idle();
		check_outputs();
		end_test("address then data");

		// W2S and W2C sit on consecutive words
		for (i = 0; i < 4; i++) begin
			push_word(1'b1, misc_addr(5'd17), 1'b0);
			push_word(1'b0, $random(seed), 1'b0);
			push_word(1'b0, $random(seed), 1'b0);
		end
		wait_idle();
		check_outputs();
		end_test("set and clear");

		// index bits point at GENIO_OUT, only the region is wrong
		push_word(1'b1, 32'h3000_003c, 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		wait_idle();
		check_outputs();
		end_test("bus error");

		push_word(1'b1, misc_addr(5'd11), 1'b0);
		push_word(1'b0, 32'h0000_0001, 1'b0);
		watch_fsel(1'b1);
		check_value("fsel_c rise delay", 3, rise_dly);
		check_value("fsel_c high cycles", 3, high_cnt);
		check_value("programn fall delay", -1, prog_dly);
		push_word(1'b1, misc_addr(5'd11), 1'b0);
		push_word(1'b0, {`RELOAD_KEY, 8'h00}, 1'b0);
		watch_fsel(1'b0);
		check_value("fsel_c rise delay", 3, rise_dly);
		check_value("fsel_c high cycles", 3, high_cnt);
		check_value("programn fall delay", 8, prog_dly);
		check_outputs();
		end_test("flash select");

		// earlier writes are still draining when the burst starts
		push_word(1'b1, misc_addr(5'd0), 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		push_word(1'b0, $random(seed), 1'b0);
		push_word(1'b1, misc_addr(5'd13), 1'b1);
		for (i = 0; i < 8; i++)
			push_word(1'b0, $random(seed), i < 7);
		wait_idle();
		check_outputs();
		end_test("strobe burst");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/soc_misc_pkg.sv
rtl/dbg_cmd_fifo.sv
rtl/dbg_bus_master.sv
rtl/misc_reg_slave.sv
rtl/flash_reload_timer.sv
rtl/dbg_soc_top.sv
verif/tb_dbg_soc.sv

// File: run.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator, runs it and looks for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_dbg_soc -f build.f -o tb_dbg_soc

./obj_dir/tb_dbg_soc | tee sim.log

if grep -qxF '** PASS **' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
